/* prog_ram_patterns.hex */
// op[127:120] 01 serial n[119:112] bytes[111:0] | 02 idle bit times[119:88] | 00 end
// 03 write addr[119:108] data[107:76] strb[75:72] | 04 read addr exp | 05 reset mode[119:116]
0310011223344F000000000000000000
03100AABBCCDD5000000000000000000
0410011BB33DD0000000000000000000
010D54454B4E4F464553540000000200
010813579BDF2468ACE0000000000000
05100000000000000000000000000000
0400013579BDF0000000000000000000
040012468ACE00000000000000000000
0410011BB33DD0000000000000000000
010954454B4E4F464553580000000000
0400013579BDF0000000000000000000
010554454B4E4F000000000000000000
02000000280000000000000000000000
010D54454B4E4F464553540000000300
010CDEADBEEF01020304CAFEF00D0000
05100000000000000000000000000000
04000DEADBEEF0000000000000000000
04001010203040000000000000000000
04002CAFEF00D0000000000000000000
010D54454B4E4F464553540000000000
05000000000000000000000000000000
04000DEADBEEF0000000000000000000
04003000000000000000000000000000
00000000000000000000000000000000

/* prog_ram_top.f */
mem_pkg.sv
boot_pkg.sv
uart_rx.sv
prog_loader.sv
byte_ram.sv
prog_ram_top.sv
tb_clkgen.sv
tb_checker.sv
tb_prog_ram.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_prog_ram
FILELIST  ?= prog_ram_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_prog_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_prog_ram;

  localparam int CLKS_PER_BIT = 8;
  localparam int BREAK_CYCLES = 200;
  localparam int RAM_DEPTH    = 1024;
  localparam int DRIVE_DLY    = 10;
  localparam int CMD_DEPTH    = 64;
  localparam int RST_WAIT     = 4 * CLKS_PER_BIT;

  // Opcodes in the top byte of each command
  localparam logic [7:0] OP_END    = 8'h00;
  localparam logic [7:0] OP_SERIAL = 8'h01;
  localparam logic [7:0] OP_IDLE   = 8'h02;
  localparam logic [7:0] OP_WRITE  = 8'h03;
  localparam logic [7:0] OP_READ   = 8'h04;
  localparam logic [7:0] OP_RESET  = 8'h05;

  logic             clk;
  logic             rst_n;
  mem_pkg::bus_wr_t bus_wr;
  logic             rd_en;
  mem_pkg::addr_t   rd_addr;
  logic             rx;
  mem_pkg::word_t   rd_data;
  logic             prog_mode;
  logic             sys_rst_n;
  mem_pkg::word_t   exp_data;
  logic             rst_exp;
  logic             rst_mode;
  logic             done;
  int               read_err;
  int               rst_err;
  int               cmd_err = 0;
  int               wait_err = 0;
  int               limit_cycles = 0;
  logic [127:0]     cmd_mem [CMD_DEPTH];

  tb_clkgen #(
    .PERIOD_NS   (100),
    .RESET_CYCLES(16),
    .HOLD_NS     (DRIVE_DLY)
  ) u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  prog_ram_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .BREAK_CYCLES(BREAK_CYCLES),
    .RAM_DEPTH   (RAM_DEPTH),
    .ADDR_W      ($bits(mem_pkg::addr_t))
  ) DUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .bus_wr_i    (bus_wr),
    .rd_en_i     (rd_en),
    .rd_addr_i   (rd_addr),
    .rx_i        (rx),
    .rd_data_o   (rd_data),
    .prog_mode_o (prog_mode),
    .sys_rst_no  (sys_rst_n)
  );

  tb_checker u_checker (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .rd_en_i     (rd_en),
    .rd_data_i   (rd_data),
    .exp_data_i  (exp_data),
    .prog_mode_i (prog_mode),
    .sys_rst_ni  (sys_rst_n),
    .rst_exp_i   (rst_exp),
    .rst_mode_i  (rst_mode),
    .done_i      (done),
    .read_err_o  (read_err),
    .rst_err_o   (rst_err)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  // 8N1 frame with the LSB first
  task automatic send_byte(input boot_pkg::byte_t value);
    rx = 1'b0;
    repeat (CLKS_PER_BIT) next_cycle();
    for (int i = 0; i < 8; i++) begin
      rx = value[i];
      repeat (CLKS_PER_BIT) next_cycle();
    end
    rx = 1'b1;
    repeat (CLKS_PER_BIT) next_cycle();
  endtask

  task automatic wait_reset_pulse(input logic mode);
    int waited;
    waited = 0;
    while (sys_rst_n !== 1'b0 && waited < RST_WAIT) begin
      next_cycle();
      waited++;
    end
    if (sys_rst_n !== 1'b0) begin
      $display("No system reset pulse within %0d clock cycles", RST_WAIT);
      wait_err++;
    end
    while (sys_rst_n === 1'b0) next_cycle();
    rst_exp  = 1'b1;
    rst_mode = mode;
    next_cycle();
    rst_exp  = 1'b0;
  endtask

  task automatic run_command(input logic [127:0] cmd);
    logic [7:0] op;
    int         n;
    op = cmd[127:120];
    case (op)
      OP_SERIAL: begin
        n = int'(cmd[119:112]);
        for (int i = 0; i < n; i++) send_byte(cmd[111-8*i -: 8]);
      end
      OP_IDLE: repeat (int'(cmd[119:88]) * CLKS_PER_BIT) next_cycle();
      OP_WRITE: begin
        bus_wr = '{addr: cmd[117:108], data: cmd[107:76], strb: cmd[75:72]};
        next_cycle();
        bus_wr.strb = '0;
      end
      OP_READ: begin
        rd_en    = 1'b1;
        rd_addr  = cmd[117:108];
        exp_data = cmd[107:76];
        next_cycle();
        rd_en    = 1'b0;
      end
      OP_RESET: wait_reset_pulse(cmd[116]);
      default: begin
        $display("Unknown command %h in the patterns file", op);
        cmd_err++;
      end
    endcase
  endtask

  // Run length in bit times with 12 per byte or command
  function automatic int run_bit_times();
    int         bits;
    logic [7:0] op;
    bits = 0;
    for (int i = 0; i < CMD_DEPTH; i++) begin
      op = cmd_mem[i][127:120];
      if (op == OP_END) break;
      if (op == OP_SERIAL) bits += 12 * int'(cmd_mem[i][119:112]);
      else if (op == OP_IDLE) bits += int'(cmd_mem[i][119:88]) + 12;
      else bits += 12;
    end
    return bits;
  endfunction

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int idx;
    bus_wr   = '0;
    rd_en    = 1'b0;
    rd_addr  = '0;
    rx       = 1'b1;
    exp_data = '0;
    rst_exp  = 1'b0;
    rst_mode = 1'b0;
    done     = 1'b0;
    $readmemh("prog_ram_patterns.hex", cmd_mem);
    limit_cycles = run_bit_times() * CLKS_PER_BIT + 2000;
    wait (rst_n === 1'b1);
    next_cycle();
    idx = 0;
    while (idx < CMD_DEPTH && cmd_mem[idx][127:120] != OP_END) begin
      run_command(cmd_mem[idx]);
      idx++;
    end
    repeat (4) next_cycle();
    done = 1'b1;
    next_cycle();
    done = 1'b0;
    next_cycle();
    $display("Error counts: %0d read, %0d reset, %0d command, %0d wait",
             read_err, rst_err, cmd_err, wait_err);
    if (read_err + rst_err + cmd_err + wait_err == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Run timed out after %0d clock cycles", limit_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  wire            clk_i,
  input  wire            rst_ni,
  input  wire            rd_en_i,
  input  mem_pkg::word_t rd_data_i,
  input  mem_pkg::word_t exp_data_i,
  input  wire            prog_mode_i,
  input  wire            sys_rst_ni,
  input  wire            rst_exp_i,
  input  wire            rst_mode_i,
  input  wire            done_i,
  output int             read_err_o,
  output int             rst_err_o
);

  mem_pkg::word_t exp_q [$];
  logic           mode_seen;
  int             low_cycles;
  int             pulses_seen;
  int             pulses_exp;

  ////////////////////////////////////////////////////////////
  // Read data, one cycle after rd_en_i
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    mem_pkg::word_t exp_word;
    if (!rst_ni) begin
      exp_q.delete();
      read_err_o = 0;
    end else begin
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        if (rd_data_i !== exp_word) begin
          $display("FAIL at time %0t: read data %h, expected %h",
                   $time, rd_data_i, exp_word);
          read_err_o++;
        end
      end
      if (rd_en_i) exp_q.push_back(exp_data_i);
    end
  end

  ////////////////////////////////////////////////////////////
  // System reset pulses and program mode
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      low_cycles  = 0;
      pulses_seen = 0;
      pulses_exp  = 0;
      mode_seen   = 1'b0;
      rst_err_o   = 0;
    end else begin
      if (!sys_rst_ni) begin
        low_cycles++;
        if (prog_mode_i) begin
          $display("FAIL at time %0t: prog_mode_o high during system reset", $time);
          rst_err_o++;
        end
      end else if (low_cycles != 0) begin
        pulses_seen++;
        if (low_cycles != 1) begin
          $display("FAIL at time %0t: reset pulse %0d cycles wide", $time, low_cycles);
          rst_err_o++;
        end
        low_cycles = 0;
      end
      if (prog_mode_i) mode_seen = 1'b1;
      // Mode seen since the previous session must match the file
      if (rst_exp_i) begin
        pulses_exp++;
        if (mode_seen != rst_mode_i) begin
          $display("FAIL at time %0t: prog_mode_o seen %0b in session, expected %0b",
                   $time, mode_seen, rst_mode_i);
          rst_err_o++;
        end
        if (prog_mode_i) begin
          $display("FAIL at time %0t: prog_mode_o still high after session", $time);
          rst_err_o++;
        end
        mode_seen = 1'b0;
      end
      if (done_i && pulses_seen != pulses_exp) begin
        $display("FAIL at time %0t: %0d reset pulses seen, %0d expected",
                 $time, pulses_seen, pulses_exp);
        rst_err_o++;
      end
    end
  end

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16,
  parameter int HOLD_NS      = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release lands just after an edge, like the rest of the stimulus
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #(HOLD_NS) rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* prog_ram_top.sv */
`timescale 1ns/1ps
`default_nettype none

module prog_ram_top #(
  parameter int unsigned CLKS_PER_BIT = 868,
  parameter int unsigned BREAK_CYCLES = 1000000,
  parameter int          RAM_DEPTH    = 1024,
  parameter int          ADDR_W       = 10
) (
  input  wire               clk_i,
  input  wire               rst_ni,
  input  mem_pkg::bus_wr_t  bus_wr_i,
  input  wire               rd_en_i,
  input  mem_pkg::addr_t    rd_addr_i,
  input  wire               rx_i,
  output mem_pkg::word_t    rd_data_o,
  output logic              prog_mode_o,
  output logic              sys_rst_no
);

  boot_pkg::byte_t   rx_byte;
  logic              rx_valid;
  mem_pkg::prog_wr_t prog_wr;

  // Serial boot path
  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_rx (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rx_i       (rx_i),
    .rx_byte_o  (rx_byte),
    .rx_valid_o (rx_valid)
  );

  prog_loader #(
    .BREAK_CYCLES(BREAK_CYCLES),
    .ADDR_W      (ADDR_W)
  ) u_prog_loader (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rx_byte_i   (rx_byte),
    .rx_valid_i  (rx_valid),
    .prog_wr_o   (prog_wr),
    .prog_mode_o (prog_mode_o),
    .sys_rst_no  (sys_rst_no)
  );

  // Program memory
  byte_ram #(
    .RAM_DEPTH(RAM_DEPTH)
  ) u_byte_ram (
    .clk_i     (clk_i),
    .bus_wr_i  (bus_wr_i),
    .prog_wr_i (prog_wr),
    .rd_en_i   (rd_en_i),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

endmodule

`default_nettype wire

/* byte_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_ram #(
  parameter int RAM_DEPTH = 1024
) (
  input  wire                clk_i,
  input  mem_pkg::bus_wr_t   bus_wr_i,
  input  mem_pkg::prog_wr_t  prog_wr_i,
  input  wire                rd_en_i,
  input  mem_pkg::addr_t     rd_addr_i,
  output mem_pkg::word_t     rd_data_o
);

  mem_pkg::word_t mem_q [RAM_DEPTH];
  mem_pkg::word_t rd_data_q;
  mem_pkg::addr_t wr_addr;
  mem_pkg::word_t wr_data;
  mem_pkg::strb_t wr_en;

  // Power-up contents are all zero
  initial begin
    for (int i = 0; i < RAM_DEPTH; i++) begin
      mem_q[i] = '0;
    end
    rd_data_q = '0;
  end

  ////////////////////////////////////////////////////////////
  // Write port select, loader wins
  ////////////////////////////////////////////////////////////

  assign wr_addr = prog_wr_i.valid ? prog_wr_i.addr : bus_wr_i.addr;
  assign wr_data = prog_wr_i.valid ? prog_wr_i.data : bus_wr_i.data;
  assign wr_en   = prog_wr_i.valid ? '1 : bus_wr_i.strb;

  always @(posedge clk_i) begin
    for (int i = 0; i < mem_pkg::NB_COL; i++) begin
      if (wr_en[i]) begin
        mem_q[wr_addr][i*mem_pkg::COL_WIDTH +: mem_pkg::COL_WIDTH] <=
          wr_data[i*mem_pkg::COL_WIDTH +: mem_pkg::COL_WIDTH];
      end
    end
    // Read before write on the same address
    if (rd_en_i) begin
      rd_data_q <= mem_q[rd_addr_i];
    end
  end

  assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

/* prog_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module prog_loader #(
  parameter int unsigned BREAK_CYCLES = 1000000,
  parameter int          ADDR_W       = 10
) (
  input  wire                clk_i,
  input  wire                rst_ni,
  input  boot_pkg::byte_t    rx_byte_i,
  input  wire                rx_valid_i,
  output mem_pkg::prog_wr_t  prog_wr_o,
  output logic               prog_mode_o,
  output logic               sys_rst_no
);

  localparam int WIN_W = 8 * boot_pkg::MAGIC_LEN;

  boot_pkg::loader_state_e state_q;
  boot_pkg::loader_state_e state_d;

  logic [WIN_W-1:0]   window_q;
  logic [3:0]         seq_cnt_q;
  logic [31:0]        break_cnt_q;
  logic [1:0]         byte_cnt_q;
  mem_pkg::word_t     count_q;
  mem_pkg::word_t     word_cnt_q;
  mem_pkg::word_t     instr_q;
  logic [ADDR_W-1:0]  wr_addr_q;
  logic               wr_valid_q;
  logic               sys_rst_q;
  logic               seq_break;
  logic               last_byte;
  mem_pkg::word_t     count_next;

  assign seq_break  = (break_cnt_q == BREAK_CYCLES);
  assign last_byte  = (byte_cnt_q == 2'd3);
  assign count_next = {count_q[23:0], rx_byte_i};

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      boot_pkg::SEQ_WAIT: begin
        if (rx_valid_i) state_d = boot_pkg::SEQ_RECEIVE;
      end
      boot_pkg::SEQ_RECEIVE: begin
        if (rx_valid_i) begin
          if (seq_cnt_q == 4'(boot_pkg::MAGIC_LEN - 1)) state_d = boot_pkg::SEQ_CHECK;
        end else if (seq_break) begin
          state_d = boot_pkg::SEQ_WAIT;
        end
      end
      boot_pkg::SEQ_CHECK: begin
        state_d = (window_q == boot_pkg::MAGIC) ? boot_pkg::SEQ_COUNT : boot_pkg::SEQ_WAIT;
      end
      // Empty image skips straight to the reset pulse
      boot_pkg::SEQ_COUNT: begin
        if (rx_valid_i && last_byte) begin
          state_d = (count_next == '0) ? boot_pkg::SEQ_FINISH : boot_pkg::SEQ_PROGRAM;
        end
      end
      boot_pkg::SEQ_PROGRAM: begin
        if (word_cnt_q == count_q) state_d = boot_pkg::SEQ_FINISH;
      end
      boot_pkg::SEQ_FINISH: state_d = boot_pkg::SEQ_WAIT;
      default:              state_d = boot_pkg::SEQ_WAIT;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= boot_pkg::SEQ_WAIT;
      seq_cnt_q   <= '0;
      break_cnt_q <= '0;
      byte_cnt_q  <= '0;
      word_cnt_q  <= '0;
      wr_addr_q   <= '0;
      wr_valid_q  <= 1'b0;
      sys_rst_q   <= 1'b1;
    end else begin
      state_q    <= state_d;
      wr_valid_q <= 1'b0;
      // Write address moves on after each loaded word
      if (wr_valid_q) wr_addr_q <= wr_addr_q + 1'b1;
      case (state_q)
        boot_pkg::SEQ_WAIT: begin
          break_cnt_q <= '0;
          byte_cnt_q  <= '0;
          word_cnt_q  <= '0;
          wr_addr_q   <= '0;
          sys_rst_q   <= 1'b1;
          seq_cnt_q   <= rx_valid_i ? 4'd1 : 4'd0;
        end
        boot_pkg::SEQ_RECEIVE: begin
          if (rx_valid_i) begin
            break_cnt_q <= '0;
            seq_cnt_q   <= seq_cnt_q + 4'd1;
          end else begin
            break_cnt_q <= break_cnt_q + 32'd1;
          end
        end
        boot_pkg::SEQ_CHECK: byte_cnt_q <= '0;
        boot_pkg::SEQ_COUNT: begin
          if (rx_valid_i) byte_cnt_q <= byte_cnt_q + 2'd1;
        end
        boot_pkg::SEQ_PROGRAM: begin
          if (rx_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
            if (last_byte) begin
              wr_valid_q <= 1'b1;
              word_cnt_q <= word_cnt_q + 32'd1;
            end
          end
        end
        boot_pkg::SEQ_FINISH: sys_rst_q <= 1'b0;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Byte assembly, MSB first
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rx_valid_i) begin
      window_q <= {window_q[WIN_W-9:0], rx_byte_i};
      if (state_q == boot_pkg::SEQ_COUNT) count_q <= count_next;
      if (state_q == boot_pkg::SEQ_PROGRAM) instr_q <= {instr_q[23:0], rx_byte_i};
    end
  end

  assign prog_wr_o = '{
    valid: wr_valid_q,
    addr:  mem_pkg::addr_t'(wr_addr_q),
    data:  instr_q
  };

  assign prog_mode_o = (state_q == boot_pkg::SEQ_PROGRAM);
  assign sys_rst_no  = sys_rst_q;

endmodule

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int unsigned CLKS_PER_BIT = 868
) (
  input  wire             clk_i,
  input  wire             rst_ni,
  input  wire             rx_i,
  output boot_pkg::byte_t rx_byte_o,
  output logic            rx_valid_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e         state_q;
  logic [1:0]        sync_q;
  logic [CNT_W-1:0]  clk_cnt_q;
  logic [2:0]        bit_idx_q;
  boot_pkg::byte_t   shift_q;
  logic              rx_s;
  logic              half_bit;
  logic              full_bit;

  assign rx_s     = sync_q[1];
  assign half_bit = (clk_cnt_q == CNT_W'(CLKS_PER_BIT / 2 - 1));
  assign full_bit = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  ////////////////////////////////////////////////////////////
  // Input synchronizer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  ////////////////////////////////////////////////////////////
  // Bit timing and framing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= RX_IDLE;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      clk_cnt_q  <= clk_cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          if (!rx_s) state_q <= RX_START;
        end
        // Recheck the line at mid start bit to reject glitches
        RX_START: begin
          if (half_bit) begin
            clk_cnt_q <= '0;
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (full_bit) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) state_q <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (full_bit) begin
            rx_valid_o <= rx_s;
            state_q    <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && full_bit) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign rx_byte_o = shift_q;

endmodule

`default_nettype wire

/* boot_pkg.sv */
`default_nettype none

package boot_pkg;

  typedef logic [7:0] byte_t;

  ////////////////////////////////////////////////////////////
  // Boot protocol
  ////////////////////////////////////////////////////////////

  localparam int MAGIC_LEN = 9;

  // Magic word that opens a programming session
  localparam logic [8*MAGIC_LEN-1:0] MAGIC = "TEKNOFEST";

  // Loader states, Gray-like encoding kept from the older design
  typedef enum logic [2:0] {
    SEQ_WAIT    = 3'b000,
    SEQ_RECEIVE = 3'b001,
    SEQ_CHECK   = 3'b011,
    SEQ_COUNT   = 3'b010,
    SEQ_PROGRAM = 3'b110,
    SEQ_FINISH  = 3'b100
  } loader_state_e;

endpackage

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

  ////////////////////////////////////////////////////////////
  // Word geometry
  ////////////////////////////////////////////////////////////

  localparam int NB_COL    = 4;
  localparam int COL_WIDTH = 8;

  typedef logic [NB_COL*COL_WIDTH-1:0] word_t;
  typedef logic [NB_COL-1:0]           strb_t;

  // Word address for the default depth of 1024
  typedef logic [9:0] addr_t;

  ////////////////////////////////////////////////////////////
  // Write requests
  ////////////////////////////////////////////////////////////

  // Processor side, lanes picked by strb
  typedef struct packed {
    addr_t addr;
    word_t data;
    strb_t strb;
  } bus_wr_t;

  // Loader side, always a full word
  typedef struct packed {
    logic  valid;
    addr_t addr;
    word_t data;
  } prog_wr_t;

endpackage

`default_nettype wire
